// ==== hw/qla_pkg.sv ====
`default_nettype none

package qla_pkg;

    // ----------------------------------------------------------
    // bus and board sizes
    // ----------------------------------------------------------
    localparam int ADDR_W     = 16;     // register address
    localparam int DATA_W     = 32;     // register data
    localparam int CUR_W      = 16;     // one current command or feedback
    localparam int NUM_AXES   = 4;
    localparam int BOARD_ID_W = 4;      // rotary switch

    // address spaces, top nibble of the address
    localparam logic [3:0] SPACE_MAIN = 4'd0;   // board + axis regs
    localparam logic [3:0] SPACE_HUB  = 4'd1;

    // per-channel offsets, low nibble
    localparam logic [3:0] OFF_ADC_DATA = 4'd0;  // feedback readback
    localparam logic [3:0] OFF_DAC_CTRL = 4'd1;  // current command
    localparam logic [3:0] OFF_STATUS   = 4'd0;  // chan 0 only

    localparam int HUB_WORDS = 16;

    // ----------------------------------------------------------
    // safety check
    // ----------------------------------------------------------
    localparam int TRIP_COUNT = 8;      // consecutive overcurrent cycles
    localparam int TRIP_CNT_W = 4;

    localparam logic [1:0] ST_ARMED   = 2'd0;
    localparam logic [1:0] ST_TIMING  = 2'd1;
    localparam logic [1:0] ST_TRIPPED = 2'd2;

    // status word layout
    localparam int STAT_AMP_EN_LSB = 0;
    localparam int STAT_TRIP_LSB   = 8;
    localparam int STAT_ID_LSB     = 24;
    localparam int STAT_CLEAR_BIT  = 31;    // write only, reads zero

    // same 16 bits seen as chan/offset or as hub word index
    typedef union packed {
        struct packed {
            logic [3:0] space;
            logic [3:0] unused;
            logic [3:0] chan;       // 0 = board, 1..4 = axes
            logic [3:0] offset;
        } main;
        struct packed {
            logic [3:0]  space;
            logic [11:0] word;
        } hub;
    } reg_addr_t;

endpackage

`default_nettype wire

// ==== hw/reg_bus_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_bus_arbiter
    import qla_pkg::*;
(
    input  wire logic              sysclk,
    input  wire logic              rst,
    // firewire host
    input  wire logic              fw_reg_wen,
    input  wire reg_addr_t         fw_reg_waddr,
    input  wire logic [DATA_W-1:0] fw_reg_wdata,
    input  wire reg_addr_t         fw_reg_raddr,
    // ethernet host
    input  wire logic              eth_reg_wen,
    input  wire reg_addr_t         eth_reg_waddr,
    input  wire logic [DATA_W-1:0] eth_reg_wdata,
    input  wire reg_addr_t         eth_reg_raddr,
    input  wire logic              eth_read_en,
    // target read words
    input  wire logic [DATA_W-1:0] rdata_axis,
    input  wire logic [DATA_W-1:0] rdata_hub,
    input  wire logic [DATA_W-1:0] rdata_board,
    // internal bus
    output logic                   reg_wen,
    output reg_addr_t              reg_waddr,
    output logic [DATA_W-1:0]      reg_wdata,
    output reg_addr_t              reg_raddr,
    output logic [DATA_W-1:0]      reg_rdata
);

    logic [DATA_W-1:0] rdata_sel;   // next read word

    // ----------------------------------------------------------
    // write stage
    // ----------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            reg_wen <= 1'b0;
        end else begin
            reg_wen <= fw_reg_wen | eth_reg_wen;    // one-cycle strobe
        end
    end

    // ethernet wins a collision, fw write is lost
    always_ff @(posedge sysclk) begin
        if (eth_reg_wen) begin
            reg_waddr <= eth_reg_waddr;
            reg_wdata <= eth_reg_wdata;
        end else begin
            reg_waddr <= fw_reg_waddr;
            reg_wdata <= fw_reg_wdata;
        end
    end

    // ----------------------------------------------------------
    // read path
    // ----------------------------------------------------------
    assign reg_raddr = eth_read_en ? eth_reg_raddr : fw_reg_raddr;   // no stage here

    always_comb begin
        rdata_sel = '0;                             // unmapped spaces read 0
        if (reg_raddr.main.space == SPACE_HUB) begin
            rdata_sel = rdata_hub;
        end else if (reg_raddr.main.space == SPACE_MAIN) begin
            if (reg_raddr.main.chan == 4'd0)
                rdata_sel = rdata_board;            // chan 0 board regs
            else
                rdata_sel = rdata_axis;
        end
    end

    // one cycle read latency
    always_ff @(posedge sysclk) begin
        if (rst) begin
            reg_rdata <= '0;
        end else begin
            reg_rdata <= rdata_sel;
        end
    end

endmodule

`default_nettype wire

// ==== hw/axis_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module axis_regs
    import qla_pkg::*;
(
    input  wire logic                           sysclk,
    input  wire logic                           rst,
    input  wire logic                           reg_wen,
    input  wire reg_addr_t                      reg_waddr,
    input  wire logic [DATA_W-1:0]              reg_wdata,
    input  wire reg_addr_t                      reg_raddr,
    input  wire logic [NUM_AXES-1:0][CUR_W-1:0] cur_fb,     // live feedback
    output logic [NUM_AXES-1:0][CUR_W-1:0]      cur_cmd,    // to the DACs
    output logic [DATA_W-1:0]                   rdata_axis
);

    logic cmd_wr;   // write hits a command offset

    assign cmd_wr = reg_wen && (reg_waddr.main.space == SPACE_MAIN)
                    && (reg_waddr.main.offset == OFF_DAC_CTRL);

    // command regs, chan n drives axis n-1
    always_ff @(posedge sysclk) begin
        if (rst) begin
            cur_cmd <= '0;
        end else if (cmd_wr) begin
            for (int a = 0; a < NUM_AXES; a++) begin
                if (reg_waddr.main.chan == 4'(a + 1))
                    cur_cmd[a] <= reg_wdata[CUR_W-1:0];
            end
        end
    end

    // readback, zero unless chan 1..4 of main space
    always_comb begin
        rdata_axis = '0;
        if (reg_raddr.main.space == SPACE_MAIN) begin
            for (int a = 0; a < NUM_AXES; a++) begin
                if (reg_raddr.main.chan == 4'(a + 1)) begin
                    if (reg_raddr.main.offset == OFF_DAC_CTRL)
                        rdata_axis[CUR_W-1:0] = cur_cmd[a];
                    else if (reg_raddr.main.offset == OFF_ADC_DATA)
                        rdata_axis[CUR_W-1:0] = cur_fb[a];  // not latched
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/hub_reg_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module hub_reg_ram
    import qla_pkg::*;
(
    input  wire logic              sysclk,
    input  wire logic              rst,
    input  wire logic              reg_wen,
    input  wire reg_addr_t         reg_waddr,
    input  wire logic [DATA_W-1:0] reg_wdata,
    input  wire reg_addr_t         reg_raddr,
    output logic [DATA_W-1:0]      rdata_hub
);

    logic [DATA_W-1:0] hub_mem [HUB_WORDS];

    // only low bits of word index decoded, upper ones alias
    always_ff @(posedge sysclk) begin
        if (rst) begin
            for (int i = 0; i < HUB_WORDS; i++)
                hub_mem[i] <= '0;
        end else if (reg_wen && (reg_waddr.hub.space == SPACE_HUB)) begin
            hub_mem[reg_waddr.hub.word[$clog2(HUB_WORDS)-1:0]] <= reg_wdata;
        end
    end

    assign rdata_hub = (reg_raddr.hub.space == SPACE_HUB)
                       ? hub_mem[reg_raddr.hub.word[$clog2(HUB_WORDS)-1:0]]
                       : '0;

endmodule

`default_nettype wire

// ==== hw/overcurrent_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module overcurrent_timer
    import qla_pkg::*;
(
    input  wire logic sysclk,
    input  wire logic rst,
    input  wire logic run,          // overcurrent seen this cycle
    output logic      expired       // held TRIP_COUNT cycles
);

    logic [TRIP_CNT_W-1:0] count;

    assign expired = (count == TRIP_CNT_W'(TRIP_COUNT));

    // any gap in run restarts the count
    always_ff @(posedge sysclk) begin
        if (rst) begin
            count <= '0;
        end else if (!run) begin
            count <= '0;
        end else if (!expired) begin
            count <= count + 1'b1;  // sticks at TRIP_COUNT
        end
    end

endmodule

`default_nettype wire

// ==== hw/safety_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module safety_fsm
    import qla_pkg::*;
(
    input  wire logic             sysclk,
    input  wire logic             rst,
    input  wire logic [CUR_W-1:0] cur_fb_axis,
    input  wire logic [CUR_W-1:0] cur_cmd_axis,
    input  wire logic             safety_clear,  // one-cycle pulse
    output logic                  tripped
);

    logic [1:0] state;
    logic       over;       // fb above 2x cmd
    logic       run;
    logic       expired;

    // unsigned compare, doubled cmd needs the extra bit
    assign over = {1'b0, cur_fb_axis} > {cur_cmd_axis, 1'b0};

    assign run     = (state == ST_TIMING) && over;
    assign tripped = (state == ST_TRIPPED);

    overcurrent_timer trip_timer (
        .sysclk  (sysclk),
        .rst     (rst),
        .run     (run),
        .expired (expired)
    );

    // ----------------------------------------------------------
    // trip state machine
    // ----------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            state <= ST_ARMED;
        end else begin
            case (state)
                ST_ARMED: begin
                    if (over)
                        state <= ST_TIMING;
                end
                ST_TIMING: begin
                    if (!over)
                        state <= ST_ARMED;      // dropped below in time
                    else if (expired)
                        state <= ST_TRIPPED;
                end
                ST_TRIPPED: begin
                    if (safety_clear)
                        state <= ST_ARMED;      // latched until host clears
                end
                default: state <= ST_ARMED;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/board_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module board_regs
    import qla_pkg::*;
(
    input  wire logic                  sysclk,
    input  wire logic                  rst,
    input  wire logic                  reg_wen,
    input  wire reg_addr_t             reg_waddr,
    input  wire logic [DATA_W-1:0]     reg_wdata,
    input  wire reg_addr_t             reg_raddr,
    input  wire logic [BOARD_ID_W-1:0] board_id,     // rotary switch
    input  wire logic [NUM_AXES-1:0]   tripped,      // from safety check
    output logic                       safety_clear,
    output logic [NUM_AXES-1:0]        amp_disable,
    output logic [DATA_W-1:0]          rdata_board
);

    logic [NUM_AXES-1:0] amp_en;
    logic                stat_wr;
    logic                stat_rd;

    // chan 0, status offset
    assign stat_wr = reg_wen && (reg_waddr.main.space == SPACE_MAIN)
                     && (reg_waddr.main.chan == 4'd0)
                     && (reg_waddr.main.offset == OFF_STATUS);
    assign stat_rd = (reg_raddr.main.space == SPACE_MAIN)
                     && (reg_raddr.main.chan == 4'd0)
                     && (reg_raddr.main.offset == OFF_STATUS);

    always_ff @(posedge sysclk) begin
        if (rst) begin
            amp_en       <= '0;
            safety_clear <= 1'b0;
        end else begin
            safety_clear <= stat_wr && reg_wdata[STAT_CLEAR_BIT];   // pulse
            if (stat_wr)
                amp_en <= reg_wdata[STAT_AMP_EN_LSB +: NUM_AXES];
        end
    end

    // off unless enabled and not tripped
    assign amp_disable = ~amp_en | tripped;

    always_comb begin
        rdata_board = '0;
        if (stat_rd) begin
            rdata_board[STAT_AMP_EN_LSB +: NUM_AXES] = amp_en;
            rdata_board[STAT_TRIP_LSB +: NUM_AXES]   = tripped;
            rdata_board[STAT_ID_LSB +: BOARD_ID_W]   = board_id;
        end
    end

endmodule

`default_nettype wire

// ==== hw/qla_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module qla_top
    import qla_pkg::*;
(
    input  wire logic                           sysclk,
    input  wire logic                           rst,
    // firewire host port
    input  wire logic                           fw_reg_wen,
    input  wire logic [ADDR_W-1:0]              fw_reg_waddr,
    input  wire logic [DATA_W-1:0]              fw_reg_wdata,
    input  wire logic [ADDR_W-1:0]              fw_reg_raddr,
    // ethernet host port
    input  wire logic                           eth_reg_wen,
    input  wire logic [ADDR_W-1:0]              eth_reg_waddr,
    input  wire logic [DATA_W-1:0]              eth_reg_wdata,
    input  wire logic [ADDR_W-1:0]              eth_reg_raddr,
    input  wire logic                           eth_read_en,
    // board side
    input  wire logic [BOARD_ID_W-1:0]          board_id,
    input  wire logic [NUM_AXES-1:0][CUR_W-1:0] cur_fb,
    output logic [DATA_W-1:0]                   reg_rdata,
    output logic [NUM_AXES-1:0][CUR_W-1:0]      cur_cmd,
    output logic [NUM_AXES-1:0]                 amp_disable
);

    // ----------------------------------------------------------
    // internal register bus
    // ----------------------------------------------------------
    logic                reg_wen;
    logic [ADDR_W-1:0]   reg_waddr;
    logic [DATA_W-1:0]   reg_wdata;
    logic [ADDR_W-1:0]   reg_raddr;
    logic [DATA_W-1:0]   rdata_axis;
    logic [DATA_W-1:0]   rdata_hub;
    logic [DATA_W-1:0]   rdata_board;
    logic                safety_clear;   // board regs to all axes
    logic [NUM_AXES-1:0] tripped;

    reg_bus_arbiter reg_bus_arbiter_inst (
        .sysclk        (sysclk),
        .rst           (rst),
        .fw_reg_wen    (fw_reg_wen),
        .fw_reg_waddr  (fw_reg_waddr),
        .fw_reg_wdata  (fw_reg_wdata),
        .fw_reg_raddr  (fw_reg_raddr),
        .eth_reg_wen   (eth_reg_wen),
        .eth_reg_waddr (eth_reg_waddr),
        .eth_reg_wdata (eth_reg_wdata),
        .eth_reg_raddr (eth_reg_raddr),
        .eth_read_en   (eth_read_en),
        .rdata_axis    (rdata_axis),
        .rdata_hub     (rdata_hub),
        .rdata_board   (rdata_board),
        .reg_wen       (reg_wen),
        .reg_waddr     (reg_waddr),
        .reg_wdata     (reg_wdata),
        .reg_raddr     (reg_raddr),
        .reg_rdata     (reg_rdata)
    );

    axis_regs axis_regs_inst (
        .sysclk     (sysclk),
        .rst        (rst),
        .reg_wen    (reg_wen),
        .reg_waddr  (reg_waddr),
        .reg_wdata  (reg_wdata),
        .reg_raddr  (reg_raddr),
        .cur_fb     (cur_fb),
        .cur_cmd    (cur_cmd),
        .rdata_axis (rdata_axis)
    );

    hub_reg_ram hub_reg_ram_inst (
        .sysclk    (sysclk),
        .rst       (rst),
        .reg_wen   (reg_wen),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_raddr (reg_raddr),
        .rdata_hub (rdata_hub)
    );

    board_regs board_regs_inst (
        .sysclk       (sysclk),
        .rst          (rst),
        .reg_wen      (reg_wen),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata),
        .reg_raddr    (reg_raddr),
        .board_id     (board_id),
        .tripped      (tripped),
        .safety_clear (safety_clear),
        .amp_disable  (amp_disable),
        .rdata_board  (rdata_board)
    );

    // one safety check per axis, fb vs 2x cmd
    for (genvar g = 0; g < NUM_AXES; g++) begin : g_safety
        safety_fsm safety_fsm_inst (
            .sysclk       (sysclk),
            .rst          (rst),
            .cur_fb_axis  (cur_fb[g]),
            .cur_cmd_axis (cur_cmd[g]),
            .safety_clear (safety_clear),
            .tripped      (tripped[g])
        );
    end

endmodule

`default_nettype wire

// ==== include/tb_qla_checks.svh ====
`ifndef TB_QLA_CHECKS_SVH
`define TB_QLA_CHECKS_SVH

// ------------------------------------------------------------
// stimulus helpers
// ------------------------------------------------------------
function automatic logic [31:0] next_rand();    // xorshift32
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic reg_addr_t main_addr(input logic [3:0] chan, input logic [3:0] off);
    reg_addr_t a;
    a             = '0;
    a.main.space  = SPACE_MAIN;
    a.main.chan   = chan;       // chan 0 is the board and 1..4 the axes
    a.main.offset = off;
    return a;
endfunction

function automatic reg_addr_t hub_addr(input logic [11:0] word);
    reg_addr_t a;
    a.hub.space = SPACE_HUB;
    a.hub.word  = word;
    return a;
endfunction

task automatic next_cycle();
    @(posedge sysclk);
    #2;                         // drive and sample clear of the edge
endtask

// one-cycle write strobe followed by three settle cycles
task automatic host_write(input bit use_eth, input reg_addr_t addr,
                          input logic [DATA_W-1:0] data);
    if (use_eth) begin
        eth_reg_wen   = 1'b1;
        eth_reg_waddr = addr;
        eth_reg_wdata = data;
    end else begin
        fw_reg_wen   = 1'b1;
        fw_reg_waddr = addr;
        fw_reg_wdata = data;
    end
    next_cycle();
    fw_reg_wen  = 1'b0;
    eth_reg_wen = 1'b0;
    repeat (3) next_cycle();
endtask

task automatic host_read(input bit use_eth, input reg_addr_t addr,
                         output logic [DATA_W-1:0] data);
    eth_read_en = use_eth;
    if (use_eth)
        eth_reg_raddr = addr;
    else
        fw_reg_raddr = addr;
    repeat (2) next_cycle();    // addr held two cycles while rdata lags one
    data        = reg_rdata;
    eth_read_en = 1'b0;
endtask

// ------------------------------------------------------------
// one compare per result type
// ------------------------------------------------------------
task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                          input logic [DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
        $display("mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
        errors++;
    end
endtask

task automatic check_cur(input string name, input logic [CUR_W-1:0] got,
                         input logic [CUR_W-1:0] exp);
    checks++;
    if (got !== exp) begin
        $display("mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
        errors++;
    end
endtask

task automatic check_mask(input string name, input logic [NUM_AXES-1:0] got,
                          input logic [NUM_AXES-1:0] exp);
    checks++;
    if (got !== exp) begin
        $display("mismatch at %0t ns: %s got %b, expected %b", $time, name, got, exp);
        errors++;
    end
endtask

`endif

// ==== tb/tb_qla_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_qla_top
    import qla_pkg::*;
();

    localparam int MAX_CYCLES = 2000;  // about ten times the whole directed run
    localparam logic [BOARD_ID_W-1:0] BOARD_ID = 4'hA;

    logic                           sysclk;
    logic                           rst;
    logic                           fw_reg_wen;
    reg_addr_t                      fw_reg_waddr;
    logic [DATA_W-1:0]              fw_reg_wdata;
    reg_addr_t                      fw_reg_raddr;
    logic                           eth_reg_wen;
    reg_addr_t                      eth_reg_waddr;
    logic [DATA_W-1:0]              eth_reg_wdata;
    reg_addr_t                      eth_reg_raddr;
    logic                           eth_read_en;
    logic [BOARD_ID_W-1:0]          board_id;
    logic [NUM_AXES-1:0][CUR_W-1:0] cur_fb;
    logic [DATA_W-1:0]              reg_rdata;
    logic [NUM_AXES-1:0][CUR_W-1:0] cur_cmd;
    logic [NUM_AXES-1:0]            amp_disable;

    logic [31:0]         rng_state;
    logic [CUR_W-1:0]    exp_cmd [NUM_AXES];  // model of the command regs
    logic [NUM_AXES-1:0] amp_en;
    int                  cycle_count = 0;
    int                  checks = 0;
    int                  errors = 0;
    int                  err_base = 0;      // errors before current test
    int                  tests = 0;

    qla_top qla_top_inst (
        .sysclk        (sysclk),
        .rst           (rst),
        .fw_reg_wen    (fw_reg_wen),
        .fw_reg_waddr  (fw_reg_waddr),
        .fw_reg_wdata  (fw_reg_wdata),
        .fw_reg_raddr  (fw_reg_raddr),
        .eth_reg_wen   (eth_reg_wen),
        .eth_reg_waddr (eth_reg_waddr),
        .eth_reg_wdata (eth_reg_wdata),
        .eth_reg_raddr (eth_reg_raddr),
        .eth_read_en   (eth_read_en),
        .board_id      (board_id),
        .cur_fb        (cur_fb),
        .reg_rdata     (reg_rdata),
        .cur_cmd       (cur_cmd),
        .amp_disable   (amp_disable)
    );

    initial sysclk = 1'b0;
    always #10 sysclk = ~sysclk;    // 20 ns period

    always @(posedge sysclk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // expected status and control words
    // ------------------------------------------------------------
    function automatic logic [DATA_W-1:0] status_word(input logic [NUM_AXES-1:0] en,
                                                      input logic [NUM_AXES-1:0] trips);
        logic [DATA_W-1:0] w;
        w = '0;
        w[STAT_AMP_EN_LSB +: NUM_AXES] = en;
        w[STAT_TRIP_LSB +: NUM_AXES]   = trips;
        w[STAT_ID_LSB +: BOARD_ID_W]   = BOARD_ID;
        return w;
    endfunction

    function automatic logic [DATA_W-1:0] ctrl_word(input logic [NUM_AXES-1:0] en,
                                                    input bit clear);
        logic [DATA_W-1:0] w;
        w = '0;
        w[STAT_AMP_EN_LSB +: NUM_AXES] = en;
        w[STAT_CLEAR_BIT]              = clear;
        return w;
    endfunction

    task automatic test_done(input string name);
        tests++;
        $display("%-12s %s, %0d errors", name, (errors == err_base) ? "ok" : "failed",
                 errors - err_base);
        err_base = errors;
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic test_reset();
        logic [DATA_W-1:0] rd;
        check_mask("amp_disable", amp_disable, '1);     // nothing enabled yet
        for (int a = 0; a < NUM_AXES; a++)
            check_cur($sformatf("cur_cmd[%0d]", a), cur_cmd[a], '0);
        host_read(1'b0, main_addr(4'd0, OFF_STATUS), rd);
        check_data("status", rd, status_word('0, '0));
        test_done("reset");
    endtask

    task automatic test_axis_cmd();
        logic [31:0]       r;
        logic [DATA_W-1:0] rd;
        for (int a = 0; a < NUM_AXES; a++) begin
            r          = next_rand();
            exp_cmd[a] = r[CUR_W-1:0] | 16'h4000;   // 2x cmd above any 15-bit fb
            host_write(1'b0, main_addr(4'(a + 1), OFF_DAC_CTRL), DATA_W'(exp_cmd[a]));
            check_cur($sformatf("cur_cmd[%0d]", a), cur_cmd[a], exp_cmd[a]);
            host_read(1'b0, main_addr(4'(a + 1), OFF_DAC_CTRL), rd);
            check_data("dac readback", rd, DATA_W'(exp_cmd[a]));
            cur_fb[a] = {1'b0, r[30:16]};
            host_read(1'b0, main_addr(4'(a + 1), OFF_ADC_DATA), rd);
            check_data("adc readback", rd, DATA_W'(cur_fb[a]));
        end
        test_done("axis_cmd");
    endtask

    task automatic test_collision();
        logic [31:0]       r;
        logic [CUR_W-1:0]  fw_val;
        logic [CUR_W-1:0]  eth_val;
        logic [DATA_W-1:0] rd;
        r             = next_rand();
        fw_val        = r[CUR_W-1:0] | 16'h4000;
        eth_val       = fw_val ^ 16'h1234;          // differs but keeps bit 14
        fw_reg_waddr  = main_addr(4'd1, OFF_DAC_CTRL);
        eth_reg_waddr = main_addr(4'd1, OFF_DAC_CTRL);
        fw_reg_wdata  = DATA_W'(fw_val);
        eth_reg_wdata = DATA_W'(eth_val);
        fw_reg_wen    = 1'b1;
        eth_reg_wen   = 1'b1;
        next_cycle();
        fw_reg_wen  = 1'b0;
        eth_reg_wen = 1'b0;
        repeat (3) next_cycle();
        exp_cmd[0] = eth_val;
        check_cur("cur_cmd[0]", cur_cmd[0], eth_val);
        fw_reg_raddr = main_addr(4'd2, OFF_DAC_CTRL);   // decoy on the fw side
        host_read(1'b1, main_addr(4'd1, OFF_DAC_CTRL), rd);
        check_data("eth readback", rd, DATA_W'(eth_val));
        test_done("collision");
    endtask

    task automatic test_hub();
        logic [DATA_W-1:0] hub_exp [HUB_WORDS];
        logic [DATA_W-1:0] rd;
        // word 0x01i has chan 1 offset i in the main view
        for (int i = 0; i < HUB_WORDS; i++) begin
            hub_exp[i] = next_rand();
            host_write(1'b1, hub_addr(12'h010 + 12'(i)), hub_exp[i]);
        end
        for (int i = 0; i < HUB_WORDS; i++) begin
            host_read(1'b1, hub_addr(12'h010 + 12'(i)), rd);
            check_data($sformatf("hub[%0d]", i), rd, hub_exp[i]);
        end
        host_read(1'b0, main_addr(4'd1, OFF_DAC_CTRL), rd);  // same low bits in main space
        check_data("dac after hub", rd, DATA_W'(exp_cmd[0]));
        check_cur("cur_cmd[0]", cur_cmd[0], exp_cmd[0]);
        test_done("hub");
    endtask

    task automatic test_trip();
        logic [DATA_W-1:0] rd;
        cur_fb = '0;                    // no axis near its limit
        amp_en = 4'b0111;
        host_write(1'b0, main_addr(4'd0, OFF_STATUS), ctrl_word(amp_en, 1'b0));
        check_mask("amp_disable", amp_disable, ~amp_en);
        // axis 1 held over 2x cmd long enough to trip
        exp_cmd[1] = 16'h0100;
        host_write(1'b0, main_addr(4'd2, OFF_DAC_CTRL), DATA_W'(exp_cmd[1]));
        cur_fb[1] = 16'h0300;
        repeat (TRIP_COUNT + 4) next_cycle();
        cur_fb[1] = 16'h0080;
        check_mask("amp_disable", amp_disable, ~amp_en | 4'b0010);
        host_read(1'b0, main_addr(4'd0, OFF_STATUS), rd);
        check_data("status", rd, status_word(amp_en, 4'b0010));
        // axis 2 burst too short
        exp_cmd[2] = 16'h0100;
        host_write(1'b0, main_addr(4'd3, OFF_DAC_CTRL), DATA_W'(exp_cmd[2]));
        cur_fb[2] = 16'h0300;
        repeat (TRIP_COUNT - 3) next_cycle();
        cur_fb[2] = 16'h0080;
        repeat (TRIP_COUNT + 4) next_cycle();
        check_mask("amp_disable", amp_disable, ~amp_en | 4'b0010);
        test_done("trip");
    endtask

    task automatic test_clear();
        logic [DATA_W-1:0] rd;
        host_write(1'b0, main_addr(4'd0, OFF_STATUS), ctrl_word(amp_en, 1'b1));
        check_mask("amp_disable", amp_disable, ~amp_en);
        host_read(1'b0, main_addr(4'd0, OFF_STATUS), rd);
        check_data("status", rd, status_word(amp_en, '0));
        test_done("clear");
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        rng_state     = 32'h5dcc_e69a;
        rst           = 1'b1;
        fw_reg_wen    = 1'b0;
        fw_reg_waddr  = '0;
        fw_reg_wdata  = '0;
        fw_reg_raddr  = '0;
        eth_reg_wen   = 1'b0;
        eth_reg_waddr = '0;
        eth_reg_wdata = '0;
        eth_reg_raddr = '0;
        eth_read_en   = 1'b0;
        board_id      = BOARD_ID;
        cur_fb        = '0;     // zero fb never trips a zero cmd
        amp_en        = '0;
        repeat (3) next_cycle();
        rst = 1'b0;
        next_cycle();
        test_reset();
        test_axis_cmd();
        test_collision();
        test_hub();
        test_trip();
        test_clear();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

`include "tb_qla_checks.svh"

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
hw/qla_pkg.sv
hw/reg_bus_arbiter.sv
hw/axis_regs.sv
hw/hub_reg_ram.sv
hw/overcurrent_timer.sv
hw/safety_fsm.sv
hw/board_regs.sv
hw/qla_top.sv
tb/tb_qla_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build tb_qla_top with Verilator, run it, then scan the log
rm -f sim.log
verilator --binary --timing -f verilog.f --top-module tb_qla_top -o sim_qla \
    && ./obj_dir/sim_qla > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0
